// ==== common/debug_defines.svh ====
`ifndef DEBUG_DEFINES_SVH
`define DEBUG_DEFINES_SVH

`define BAUD_DIVISOR     2      // Clocks per oversampling tick
`define OVERSAMPLE       16     // Ticks per serial bit

`define IF_ID_WIDTH      32
`define MEM_WB_WIDTH     71

`define IMEM_ADDR_WIDTH  6
`define INSTR_WIDTH      32

`define TX_FIFO_DEPTH    16     // Must be a power of two

`define OP_DUMP_IF_ID    8'h01
`define OP_DUMP_MEM_WB   8'h05
`define OP_LOAD          8'h07
`define OP_CONT          8'h08
`define OP_STEP_MODE     8'h09
`define OP_STEP          8'h0A

`define ACK_BYTE         8'h52  // ASCII 'R'

`endif

// ==== common/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // Frame position, shared by the receiver and the transmitter
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        START = 3'd1,
        DATA  = 3'd2,
        STOP  = 3'd3
    } uart_state_t;

endpackage

`default_nettype wire

// ==== common/debug_pkg.sv ====
`default_nettype none

`include "debug_defines.svh"

package debug_pkg;

    typedef enum logic [7:0] {
        CMD_DUMP_IF_ID  = `OP_DUMP_IF_ID,
        CMD_DUMP_MEM_WB = `OP_DUMP_MEM_WB,
        CMD_LOAD        = `OP_LOAD,
        CMD_CONT        = `OP_CONT,
        CMD_STEP_MODE   = `OP_STEP_MODE,
        CMD_STEP        = `OP_STEP
    } cmd_t;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        DUMP_BYTE  = 3'd1,  // Push one snapshot byte
        DUMP_WAIT  = 3'd2,  // FIFO full, hold the byte
        LOAD_COUNT = 3'd3,  // Expect the word count
        LOAD_BYTE  = 3'd4,  // Expect instruction bytes
        ACK        = 3'd5,
        STEP       = 3'd6
    } ctrl_state_t;

    typedef logic [`IF_ID_WIDTH-1:0]  if_id_t;
    typedef logic [`MEM_WB_WIDTH-1:0] mem_wb_t;

    // Widest latch rounded up to whole bytes
    typedef logic [((`MEM_WB_WIDTH + 7) / 8) * 8 - 1:0] dump_snap_t;

endpackage

`default_nettype wire

// ==== uart/uart_baud_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "debug_defines.svh"

module uart_baud_gen (
    input  wire  i_clk,
    input  wire  i_reset,
    output logic o_tick
);

    localparam int CNT_W = $clog2(`BAUD_DIVISOR + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else if (count == CNT_W'(`BAUD_DIVISOR - 1)) begin
            count  <= '0;
            o_tick <= 1'b1;         // One clock wide
        end else begin
            count  <= count + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== uart/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "debug_defines.svh"

module uart_rx
    import uart_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_tick,
    input  wire        i_rx,
    output logic [7:0] o_data,
    output logic       o_valid
);

    localparam int TICK_W = $clog2(`OVERSAMPLE);

    uart_state_t       state;
    logic              rx_meta;
    logic              rx_sync;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    logic [7:0]        shift;
    logic              half_bit;
    logic              full_bit;

    assign half_bit = i_tick && (tick_cnt == TICK_W'(`OVERSAMPLE / 2 - 1));
    assign full_bit = i_tick && (tick_cnt == TICK_W'(`OVERSAMPLE - 1));

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            rx_meta  <= 1'b1;       // Line idles high
            rx_sync  <= 1'b1;
            state    <= IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_valid  <= 1'b0;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            o_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (!rx_sync) begin
                        tick_cnt <= '0;
                        state    <= START;
                    end
                end
                START: begin
                    if (half_bit) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? IDLE : DATA;  // Glitch returns to idle
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (full_bit) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= STOP;
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (full_bit) begin
                        o_valid <= rx_sync;  // Framing error drops the byte
                        state   <= IDLE;
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == DATA && full_bit)
            shift <= {rx_sync, shift[7:1]};  // LSB arrives first
        if (state == STOP && full_bit)
            o_data <= shift;
    end

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "debug_defines.svh"

module uart_tx
    import uart_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_tick,
    input  wire        i_empty,
    input  wire  [7:0] i_data,
    output logic       o_pop,
    output logic       o_tx
);

    localparam int TICK_W = $clog2(`OVERSAMPLE);

    uart_state_t       state;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    logic [7:0]        shift;
    logic              bit_done;

    assign bit_done = i_tick && (tick_cnt == TICK_W'(`OVERSAMPLE - 1));
    assign o_pop    = (state == IDLE) && !i_empty;  // Head byte taken as the frame starts

    always_comb begin
        case (state)
            START:   o_tx = 1'b0;
            DATA:    o_tx = shift[0];
            default: o_tx = 1'b1;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!i_empty) begin
                        tick_cnt <= '0;
                        state    <= START;
                    end
                end
                START: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= DATA;
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= STOP;
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_done)
                        state <= IDLE;
                    else if (i_tick)
                        tick_cnt <= tick_cnt + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_pop)
            shift <= i_data;
        else if (state == DATA && bit_done)
            shift <= shift >> 1;
    end

endmodule

`default_nettype wire

// ==== source/tx_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "debug_defines.svh"

module tx_fifo (
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_push,
    input  wire  [7:0] i_data,
    input  wire        i_pop,
    output logic [7:0] o_data,
    output logic       o_full,
    output logic       o_empty
);

    localparam int ADDR_W = $clog2(`TX_FIFO_DEPTH);

    logic [7:0]      mem [`TX_FIFO_DEPTH];
    logic [ADDR_W:0] wr_ptr;    // Extra MSB tells full from empty
    logic [ADDR_W:0] rd_ptr;
    logic            do_push;
    logic            do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
                  && (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign o_data  = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push)
            mem[wr_ptr[ADDR_W-1:0]] <= i_data;
    end

endmodule

`default_nettype wire

// ==== source/debug_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "debug_defines.svh"

module debug_ctrl
    import debug_pkg::*;
(
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire                         i_rx_valid,
    input  wire  [7:0]                  i_rx_data,
    input  wire  if_id_t                i_if_id,
    input  wire  mem_wb_t               i_mem_wb,
    input  wire                         i_fifo_full,
    output logic                        o_fifo_push,
    output logic [7:0]                  o_fifo_data,
    output logic                        o_imem_we,
    output logic [`IMEM_ADDR_WIDTH-1:0] o_imem_addr,
    output logic [`INSTR_WIDTH-1:0]     o_imem_data,
    output logic                        o_cpu_enable,
    output logic                        o_step_mode
);

    localparam int IF_ID_BYTES  = (`IF_ID_WIDTH + 7) / 8;
    localparam int MEM_WB_BYTES = (`MEM_WB_WIDTH + 7) / 8;
    localparam int SNAP_WIDTH   = $bits(dump_snap_t);

    ctrl_state_t             state;
    cmd_t                    cmd;
    dump_snap_t              snap;
    logic [3:0]              dump_left;     // Bytes still to push
    logic [1:0]              byte_idx;
    logic [7:0]              word_left;
    logic [`INSTR_WIDTH-1:0] load_word;
    logic                    loading;
    logic                    step_mode;
    logic                    step_pulse;

    assign cmd = cmd_t'(i_rx_data);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state       <= IDLE;
            dump_left   <= '0;
            byte_idx    <= '0;
            word_left   <= '0;
            loading     <= 1'b0;
            step_mode   <= 1'b0;
            step_pulse  <= 1'b0;
            o_imem_we   <= 1'b0;
            o_imem_addr <= '0;
        end else begin
            step_pulse <= 1'b0;
            o_imem_we  <= 1'b0;
            if (o_imem_we)
                o_imem_addr <= o_imem_addr + 1'b1;
            case (state)
                IDLE: begin
                    if (i_rx_valid) begin
                        case (cmd)
                            CMD_DUMP_IF_ID: begin
                                dump_left <= 4'(IF_ID_BYTES);
                                state     <= DUMP_BYTE;
                            end
                            CMD_DUMP_MEM_WB: begin
                                dump_left <= 4'(MEM_WB_BYTES);
                                state     <= DUMP_BYTE;
                            end
                            CMD_LOAD: begin
                                loading     <= 1'b1;    // CPU halted until the ACK
                                o_imem_addr <= '0;
                                state       <= LOAD_COUNT;
                            end
                            CMD_CONT:      step_mode <= 1'b0;
                            CMD_STEP_MODE: step_mode <= 1'b1;
                            CMD_STEP:      state <= STEP;
                            default:       state <= IDLE;
                        endcase
                    end
                end
                DUMP_BYTE: begin
                    if (i_fifo_full) begin
                        state <= DUMP_WAIT;
                    end else begin
                        dump_left <= dump_left - 1'b1;
                        if (dump_left == 4'd1)
                            state <= ACK;
                    end
                end
                DUMP_WAIT: begin
                    if (!i_fifo_full)
                        state <= DUMP_BYTE;
                end
                LOAD_COUNT: begin
                    if (i_rx_valid) begin
                        word_left <= i_rx_data;
                        byte_idx  <= '0;
                        state     <= (i_rx_data == 8'd0) ? ACK : LOAD_BYTE;
                    end
                end
                LOAD_BYTE: begin
                    if (i_rx_valid) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            o_imem_we <= 1'b1;  // Word complete in load_word
                            word_left <= word_left - 1'b1;
                            if (word_left == 8'd1)
                                state <= ACK;
                        end
                    end
                end
                ACK: begin
                    if (!i_fifo_full) begin
                        loading <= 1'b0;
                        state   <= IDLE;
                    end
                end
                STEP: begin
                    step_pulse <= step_mode;
                    state      <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Snapshot taken once so the reply reflects a single cycle
    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_rx_valid && cmd == CMD_DUMP_IF_ID)
            snap <= {{(SNAP_WIDTH - `IF_ID_WIDTH){1'b0}}, i_if_id};
        else if (state == IDLE && i_rx_valid && cmd == CMD_DUMP_MEM_WB)
            snap <= {{(SNAP_WIDTH - `MEM_WB_WIDTH){1'b0}}, i_mem_wb};
        else if (state == DUMP_BYTE && o_fifo_push)
            snap <= snap >> 8;
        if (state == LOAD_BYTE && i_rx_valid)
            load_word <= {i_rx_data, load_word[`INSTR_WIDTH-1:8]};  // Little-endian
    end

    assign o_fifo_push  = (state == DUMP_BYTE || state == ACK) && !i_fifo_full;
    assign o_fifo_data  = (state == ACK) ? `ACK_BYTE : snap[7:0];
    assign o_imem_data  = load_word;
    assign o_step_mode  = step_mode;
    assign o_cpu_enable = !loading && (!step_mode || step_pulse);

endmodule

`default_nettype wire

// ==== source/debug_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "debug_defines.svh"

module debug_unit
    import debug_pkg::*;
(
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire                         i_uart_rx,
    output wire                         o_uart_tx,
    input  wire  if_id_t                i_if_id,
    input  wire  mem_wb_t               i_mem_wb,
    output wire                         o_imem_we,
    output wire  [`IMEM_ADDR_WIDTH-1:0] o_imem_addr,
    output wire  [`INSTR_WIDTH-1:0]     o_imem_data,
    output wire                         o_cpu_enable,
    output wire                         o_step_mode
);

    wire       tick;
    wire [7:0] rx_data;
    wire       rx_valid;
    wire       fifo_push;
    wire [7:0] fifo_wdata;
    wire       fifo_full;
    wire       fifo_empty;
    wire [7:0] fifo_head;
    wire       fifo_pop;

    uart_baud_gen u_baud_gen (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx u_uart_rx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_rx    (i_uart_rx),
        .o_data  (rx_data),
        .o_valid (rx_valid)
    );

    debug_ctrl u_debug_ctrl (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_valid   (rx_valid),
        .i_rx_data    (rx_data),
        .i_if_id      (i_if_id),
        .i_mem_wb     (i_mem_wb),
        .i_fifo_full  (fifo_full),
        .o_fifo_push  (fifo_push),
        .o_fifo_data  (fifo_wdata),
        .o_imem_we    (o_imem_we),
        .o_imem_addr  (o_imem_addr),
        .o_imem_data  (o_imem_data),
        .o_cpu_enable (o_cpu_enable),
        .o_step_mode  (o_step_mode)
    );

    tx_fifo u_tx_fifo (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_push  (fifo_push),
        .i_data  (fifo_wdata),
        .i_pop   (fifo_pop),
        .o_data  (fifo_head),
        .o_full  (fifo_full),
        .o_empty (fifo_empty)
    );

    uart_tx u_uart_tx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_empty (fifo_empty),
        .i_data  (fifo_head),
        .o_pop   (fifo_pop),
        .o_tx    (o_uart_tx)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_debug_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "debug_defines.svh"

module tb_debug_unit;
    import debug_pkg::*;

    localparam int BIT_CLKS     = `BAUD_DIVISOR * `OVERSAMPLE;
    localparam int FRAME_CLKS   = 10 * BIT_CLKS;
    localparam int MEM_WB_BYTES = (`MEM_WB_WIDTH + 7) / 8;
    localparam int FRAMES_SENT  = 1 + 1 + (2 + 4 * 8) + 1 + 4 + 1 + 1 + 1;
    localparam int FRAMES_EXP   = (4 + 1) + (MEM_WB_BYTES + 1) + 1 + (4 + 1);
    localparam int MAX_CYCLES   = (FRAMES_SENT + FRAMES_EXP) * FRAME_CLKS + 2000;

    logic                        i_clk;
    logic                        i_reset;
    logic                        i_uart_rx;
    logic                        o_uart_tx;
    if_id_t                      i_if_id;
    mem_wb_t                     i_mem_wb;
    logic                        o_imem_we;
    logic [`IMEM_ADDR_WIDTH-1:0] o_imem_addr;
    logic [`INSTR_WIDTH-1:0]     o_imem_data;
    logic                        o_cpu_enable;
    logic                        o_step_mode;

    logic [7:0]                  rx_q[$];       // Bytes seen on o_uart_tx
    logic [`IMEM_ADDR_WIDTH-1:0] we_addr_q[$];
    logic [`INSTR_WIDTH-1:0]     we_data_q[$];
    logic [7:0]                  rx_byte;
    logic [31:0]                 rng_state;
    bit                          hold_low;      // o_cpu_enable must stay low
    int                          load_words;
    int                          en_count;
    int                          error_count;
    int                          checks_done;
    int                          cycle_count;

    debug_unit u_dut (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_uart_rx    (i_uart_rx),
        .o_uart_tx    (o_uart_tx),
        .i_if_id      (i_if_id),
        .i_mem_wb     (i_mem_wb),
        .o_imem_we    (o_imem_we),
        .o_imem_addr  (o_imem_addr),
        .o_imem_data  (o_imem_data),
        .o_cpu_enable (o_cpu_enable),
        .o_step_mode  (o_step_mode)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks_done++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_word(input logic [`IMEM_ADDR_WIDTH-1:0] got_addr,
                              input logic [`IMEM_ADDR_WIDTH-1:0] exp_addr,
                              input logic [`INSTR_WIDTH-1:0] got,
                              input logic [`INSTR_WIDTH-1:0] exp);
        checks_done++;
        if (got_addr !== exp_addr) begin
            $display("ERROR at %0t: o_imem_addr got %h expected %h", $time, got_addr, exp_addr);
            error_count++;
        end
        if (got !== exp) begin
            $display("ERROR at %0t: o_imem_data[%0d] got %h expected %h",
                     $time, exp_addr, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks_done++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_snapshot(input string name, input mem_wb_t got, input mem_wb_t exp);
        checks_done++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        checks_done++;
        if (got != exp) begin
            $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Host side 8N1 frame sent LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge i_clk);
            i_uart_rx <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge i_clk);
        end
    endtask

    task automatic wait_bytes(input int n, output bit ok);
        int waited;
        waited = 0;
        while (rx_q.size() < n && waited < n * FRAME_CLKS + 400) begin
            @(posedge i_clk);
            waited++;
        end
        ok = (rx_q.size() >= n);
        if (!ok) begin
            $display("Reply missing: only %0d of %0d bytes arrived", rx_q.size(), n);
            error_count++;
        end
    endtask

    task automatic dump_latch(input logic [7:0] op, input int nbytes, input mem_wb_t exp_snap);
        logic [8*MEM_WB_BYTES-1:0] exp_pad;
        logic [8*MEM_WB_BYTES-1:0] got_pad;
        logic [7:0]                b;
        bit                        ok;
        exp_pad = '0;
        exp_pad[`MEM_WB_WIDTH-1:0] = exp_snap;  // Zero padding on top
        got_pad = '0;
        rx_q.delete();
        send_byte(op);
        wait_bytes(nbytes + 1, ok);
        if (ok) begin
            for (int k = 0; k < nbytes; k++) begin
                b = rx_q.pop_front();
                check_byte($sformatf("o_uart_tx byte %0d", k), b, exp_pad[8*k +: 8]);
                got_pad[8*k +: 8] = b;
            end
            check_byte("o_uart_tx ack", rx_q.pop_front(), `ACK_BYTE);
            check_snapshot("dump snapshot", got_pad[`MEM_WB_WIDTH-1:0], exp_snap);
        end
        rx_q.delete();
    endtask

    task automatic load_program();
        logic [`INSTR_WIDTH-1:0] words[$];
        int                      n;
        bit                      ok;
        n = 1 + int'(rand32() % 8);
        for (int i = 0; i < n; i++)
            words.push_back(rand32());
        we_addr_q.delete();
        we_data_q.delete();
        load_words = n;
        send_byte(`OP_LOAD);
        hold_low = 1'b1;
        send_byte(8'(n));
        for (int i = 0; i < n; i++) begin
            for (int k = 0; k < 4; k++)
                send_byte(words[i][8*k +: 8]);
        end
        wait_bytes(1, ok);
        if (ok)
            check_byte("o_uart_tx ack", rx_q.pop_front(), `ACK_BYTE);
        if (we_addr_q.size() != n) begin
            $display("Program load gave %0d memory writes instead of %0d", we_addr_q.size(), n);
            error_count++;
        end else begin
            for (int i = 0; i < n; i++)
                check_word(we_addr_q[i], `IMEM_ADDR_WIDTH'(i), we_data_q[i], words[i]);
        end
        @(negedge i_clk);
        check_flag("o_cpu_enable", o_cpu_enable, 1'b1);
        check_flag("o_step_mode", o_step_mode, 1'b0);
    endtask

    task automatic exercise_modes();
        int steps;
        rx_q.delete();
        send_byte(`OP_STEP_MODE);
        repeat (20) @(negedge i_clk);
        check_flag("o_step_mode", o_step_mode, 1'b1);
        check_flag("o_cpu_enable", o_cpu_enable, 1'b0);
        steps = 1 + int'(rand32() % 4);
        for (int s = 0; s < steps; s++) begin
            @(posedge i_clk);
            en_count = 0;
            send_byte(`OP_STEP);
            repeat (20) @(posedge i_clk);
            check_cycles("o_cpu_enable high cycles per step", en_count, 1);
        end
        send_byte(`OP_CONT);
        repeat (4) @(posedge i_clk);
        en_count = 0;
        repeat (64) @(posedge i_clk);
        check_cycles("o_cpu_enable high cycles in continuous mode", en_count, 64);
        @(negedge i_clk);
        check_flag("o_step_mode", o_step_mode, 1'b0);
        repeat (FRAME_CLKS) @(posedge i_clk);
        check_cycles("bytes after mode commands", rx_q.size(), 0);
    endtask

    task automatic send_unknown_opcode();
        logic [31:0] r;
        logic [7:0]  op;
        r  = rand32();
        op = r[7:0];
        while (op inside {`OP_DUMP_IF_ID, `OP_DUMP_MEM_WB, `OP_LOAD,
                          `OP_CONT, `OP_STEP_MODE, `OP_STEP}) begin
            r  = rand32();
            op = r[7:0];
        end
        rx_q.delete();
        we_addr_q.delete();
        send_byte(op);
        repeat (FRAME_CLKS + 80) @(posedge i_clk);
        check_cycles("bytes after unknown opcode", rx_q.size(), 0);
        check_cycles("memory writes after unknown opcode", we_addr_q.size(), 0);
    endtask

    // Mid-bit sampling of the DUT's serial output
    initial begin
        forever begin
            @(negedge i_clk);
            if (o_uart_tx === 1'b0) begin
                repeat (BIT_CLKS / 2) @(negedge i_clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge i_clk);
                    rx_byte[i] = o_uart_tx;
                end
                repeat (BIT_CLKS) @(negedge i_clk);
                if (o_uart_tx !== 1'b1) begin
                    $display("Serial frame at %0t has a bad stop bit", $time);
                    error_count++;
                end
                rx_q.push_back(rx_byte);
            end
        end
    end

    // CPU-side observers
    initial begin
        forever begin
            @(negedge i_clk);
            if (o_cpu_enable === 1'b1)
                en_count++;
            if (o_imem_we === 1'b1) begin
                we_addr_q.push_back(o_imem_addr);
                we_data_q.push_back(o_imem_data);
            end
            if (hold_low && o_cpu_enable !== 1'b0) begin
                $display("o_cpu_enable went high during a program load at %0t", $time);
                error_count++;
                hold_low = 1'b0;
            end
            if (o_imem_we === 1'b1 && we_addr_q.size() == load_words)
                hold_low = 1'b0;    // Enable may return after the last word is written
        end
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with the test sequence unfinished", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        if_id_t      if_val;
        mem_wb_t     mw_val;
        logic [95:0] wide;
        rng_state   = 32'h24af;
        error_count = 0;
        checks_done = 0;
        cycle_count = 0;
        en_count    = 0;
        load_words  = 0;
        hold_low    = 1'b0;
        i_reset     = 1'b1;
        i_uart_rx   = 1'b1;     // Line idles high
        i_if_id     = '0;
        i_mem_wb    = '0;
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        check_flag("o_cpu_enable", o_cpu_enable, 1'b1);
        check_flag("o_step_mode", o_step_mode, 1'b0);
        check_flag("o_imem_we", o_imem_we, 1'b0);
        check_flag("o_uart_tx", o_uart_tx, 1'b1);

        @(posedge i_clk);
        if_val = rand32();
        i_if_id <= if_val;
        dump_latch(`OP_DUMP_IF_ID, 4, mem_wb_t'(if_val));

        @(posedge i_clk);
        wide = {rand32(), rand32(), rand32()};
        mw_val = wide[`MEM_WB_WIDTH-1:0];
        i_mem_wb <= mw_val;
        dump_latch(`OP_DUMP_MEM_WB, MEM_WB_BYTES, mw_val);

        load_program();
        exercise_modes();
        send_unknown_opcode();

        @(posedge i_clk);
        if_val = rand32();
        i_if_id <= if_val;
        dump_latch(`OP_DUMP_IF_ID, 4, mem_wb_t'(if_val));

        $display("Checks: %0d, errors: %0d", checks_done, error_count);
        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/uart_pkg.sv
common/debug_pkg.sv
uart/uart_baud_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
source/tx_fifo.sv
source/debug_ctrl.sv
source/debug_unit.sv
testbench/tb_debug_unit.sv

// ==== Makefile ====
TOP := tb_debug_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps -f sim.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | awk '{ print } /^Simulation passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
